// ==== list.f ====
+incdir+common
common/rob_pkg.sv
logic/flag_table.sv
rob/rob_entry_store.sv
rob/rob_status.sv
rob/rob_top.sv
test/rob_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
rm -rf obj_dir sim.log && \
verilator --binary --timing --assert -f list.f --top-module rob_tb -o rob_sim && \
./obj_dir/rob_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^STATUS: PASS$" sim.log 2>/dev/null && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

// ==== test/rob_tb.sv ====
`default_nettype none

`include "rob_defines.svh"

module rob_tb import rob_pkg::*; ();

    localparam int SRC_CYCLES    = 40;
    localparam int RAND_CYCLES   = 300;
    localparam int DRAIN_CYCLES  = 24;
    // reset, directed steps, both loops and four drains
    localparam int TOTAL_CYCLES  = 5 + 40 + SRC_CYCLES + RAND_CYCLES + 4 * DRAIN_CYCLES;
    localparam int NO_COMMIT     = 0;
    localparam int RANDOM_COMMIT = 1;
    localparam int GREEDY_COMMIT = 2;

    logic                  clk;
    logic                  reset_i;
    logic                  flush_i;
    rob_dispatch_t [1:0]   dispatch_i;
    rob_cdb_t      [1:0]   cdb_i;
    logic [1:0]            commit_req_i;
    logic                  dispatch_ready_o;
    rob_src_reply_t [1:0]  src_reply_o;
    logic [1:0]            commit_valid_o;
    rob_commit_t    [1:0]  commit_o;

    rob_top DUT (
        .clk, .reset_i, .flush_i, .dispatch_i, .cdb_i, .commit_req_i,
        .dispatch_ready_o, .src_reply_o, .commit_valid_o, .commit_o
    );

    always #50 clk = ~clk;

    // stimulus side bookkeeping
    logic [15:0]            lfsr_q;
    logic [`ROB_WIDTH-1:0]  next_id;
    logic [`ROB_WIDTH-1:0]  pending [$];
    int                     in_flight;
    string                  test_name;

    // reference model state
    logic [4:0]             m_areg   [`ROB_DEPTH];
    logic [31:0]            m_pc     [`ROB_DEPTH];
    inst_class_e            m_iclass [`ROB_DEPTH];
    logic [`ROB_DATA_W-1:0] m_data   [`ROB_DEPTH];
    logic                   m_done   [`ROB_DEPTH];
    logic [`ROB_WIDTH-1:0]  m_tail;
    logic [`ROB_WIDTH:0]    m_count;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            $display("Error [%s] %s: expected %0h, actual %0h", test_name, what,
                     expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    function automatic logic room_for_pair();
        return m_count <= (`ROB_WIDTH+1)'(`ROB_DEPTH - 2);
    endfunction

    // entry i offered only when it is in the buffer and done
    function automatic logic [1:0] done_at_tail();
        logic [1:0] v;
        for (int i = 0; i < 2; i++) begin
            v[i] = (m_count > (`ROB_WIDTH+1)'(i)) && m_done[m_tail + `ROB_WIDTH'(i)];
        end
        return v;
    endfunction

    function automatic rob_commit_t commit_record(input int i);
        rob_commit_t           r;
        logic [`ROB_WIDTH-1:0] idx;
        idx      = m_tail + `ROB_WIDTH'(i);
        r.areg   = m_areg[idx];
        r.pc     = m_pc[idx];
        r.iclass = m_iclass[idx];
        r.data   = m_data[idx];
        return r;
    endfunction

    function automatic rob_src_reply_t lookup_sources(input int s);
        rob_src_reply_t r;
        for (int k = 0; k < 2; k++) begin
            r.data[k]     = m_data[dispatch_i[s].src_id[k]];
            r.complete[k] = m_done[dispatch_i[s].src_id[k]];
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // compare then advance the model
    ////////////////////////////////////////

    always @(posedge clk) begin : compare_and_update
        logic [1:0]     exp_valid;
        rob_src_reply_t exp_src;
        int             nd;
        int             nc;
        if (!reset_i) begin
            exp_valid = done_at_tail();
            check_value("dispatch_ready", 128'(room_for_pair()), 128'(dispatch_ready_o));
            check_value("commit_valid", 128'(exp_valid), 128'(commit_valid_o));
            for (int i = 0; i < 2; i++) begin
                if (exp_valid[i]) begin
                    check_value($sformatf("commit slot %0d", i), 128'(commit_record(i)),
                                128'(commit_o[i]));
                end
            end
            for (int s = 0; s < 2; s++) begin
                exp_src = lookup_sources(s);
                check_value($sformatf("src complete slot %0d", s), 128'(exp_src.complete),
                            128'(src_reply_o[s].complete));
                for (int k = 0; k < 2; k++) begin
                    // data only means something once the result arrived
                    if (exp_src.complete[k]) begin
                        check_value($sformatf("src data %0d.%0d", s, k),
                                    128'(exp_src.data[k]), 128'(src_reply_o[s].data[k]));
                    end
                end
            end
        end
        if (reset_i || flush_i) begin
            for (int e = 0; e < `ROB_DEPTH; e++) begin
                m_done[e] = 1'b0;
            end
            m_tail  = '0;
            m_count = '0;
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (dispatch_i[s].valid) begin
                    m_areg[dispatch_i[s].rob_id]   = dispatch_i[s].areg;
                    m_pc[dispatch_i[s].rob_id]     = dispatch_i[s].pc;
                    m_iclass[dispatch_i[s].rob_id] = dispatch_i[s].iclass;
                    m_done[dispatch_i[s].rob_id]   = 1'b0;
                end
            end
            for (int j = 0; j < 2; j++) begin
                if (cdb_i[j].valid) begin
                    m_data[cdb_i[j].rob_id] = cdb_i[j].data;
                    m_done[cdb_i[j].rob_id] = 1'b1;
                end
            end
            nd      = int'(dispatch_i[0].valid) + int'(dispatch_i[1].valid);
            nc      = int'(commit_req_i[0]) + int'(commit_req_i[1]);
            m_tail  = m_tail + `ROB_WIDTH'(nc);
            m_count = m_count + (`ROB_WIDTH+1)'(nd) - (`ROB_WIDTH+1)'(nc);
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    // one cycle of inputs applied on the falling edge
    task automatic run_cycle(input int n_disp, input int n_wb, input int mode,
                             input bit youngest);
        int                    idx;
        logic [`ROB_WIDTH-1:0] id;
        logic [1:0]            req;
        @(negedge clk);
        flush_i    = 1'b0;
        dispatch_i = '0;
        cdb_i      = '0;
        // results go only to entries already in flight
        for (int j = 0; j < n_wb && j < 2; j++) begin
            if (pending.size() > 0) begin
                if (youngest) begin
                    id = pending.pop_back();
                end else begin
                    idx = int'(rand_bits(4)) % pending.size();
                    id  = pending[idx];
                    pending.delete(idx);
                end
                cdb_i[j].valid  = 1'b1;
                cdb_i[j].rob_id = id;
                cdb_i[j].data   = rand_bits(32);
            end
        end
        if (dispatch_ready_o) begin
            for (int s = 0; s < n_disp && s < 2; s++) begin
                dispatch_i[s].valid     = 1'b1;
                dispatch_i[s].rob_id    = next_id;
                dispatch_i[s].areg      = 5'(rand_bits(5));
                dispatch_i[s].pc        = rand_bits(30) << 2;
                dispatch_i[s].iclass    = inst_class_e'(2'(rand_bits(2)));
                dispatch_i[s].src_id[0] = `ROB_WIDTH'(rand_bits(`ROB_WIDTH));
                dispatch_i[s].src_id[1] = `ROB_WIDTH'(rand_bits(`ROB_WIDTH));
                pending.push_back(next_id);
                next_id   = next_id + `ROB_WIDTH'(1);
                in_flight = in_flight + 1;
            end
        end
        req = '0;
        if (mode == GREEDY_COMMIT) begin
            req = commit_valid_o;
        end else if (mode == RANDOM_COMMIT) begin
            req[0] = commit_valid_o[0] & 1'(rand_bits(1));
            req[1] = commit_valid_o[1] & 1'(rand_bits(1));
        end
        req[1]       = req[1] & req[0];
        commit_req_i = req;
        in_flight    = in_flight - int'(req[0]) - int'(req[1]);
    endtask

    task automatic drain();
        while (in_flight > 0) begin
            run_cycle(0, 2, GREEDY_COMMIT, 1'b0);
        end
        run_cycle(0, 0, NO_COMMIT, 1'b0);
    endtask

    task automatic flush_cycle();
        @(negedge clk);
        dispatch_i   = '0;
        cdb_i        = '0;
        commit_req_i = '0;
        flush_i      = 1'b1;
        pending.delete();
        next_id   = '0;
        in_flight = 0;
    endtask

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        flush_i      = 1'b0;
        dispatch_i   = '0;
        cdb_i        = '0;
        commit_req_i = '0;
        lfsr_q       = 16'd47777;
        next_id      = '0;
        in_flight    = 0;
        test_name    = "reset";
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        check_value("commit_valid", 128'(0), 128'(commit_valid_o));
        check_value("dispatch_ready", 128'(1), 128'(dispatch_ready_o));

        test_name = "out of order";
        repeat (2) run_cycle(2, 0, NO_COMMIT, 1'b0);
        repeat (3) run_cycle(0, 1, NO_COMMIT, 1'b1);
        run_cycle(0, 0, NO_COMMIT, 1'b0);
        // younger ones done while the oldest still waits
        check_value("commit_valid", 128'(2'b10), 128'(commit_valid_o));

        test_name = "commit pair";
        run_cycle(0, 1, NO_COMMIT, 1'b1);
        run_cycle(0, 0, NO_COMMIT, 1'b0);
        check_value("commit_valid", 128'(2'b11), 128'(commit_valid_o));
        drain();

        test_name = "source lookup";
        repeat (SRC_CYCLES) run_cycle(2, 2, GREEDY_COMMIT, 1'b0);
        drain();

        test_name = "fill";
        repeat (8) run_cycle(2, 0, NO_COMMIT, 1'b0);
        run_cycle(0, 0, NO_COMMIT, 1'b0);
        check_value("dispatch_ready", 128'(0), 128'(dispatch_ready_o));
        drain();
        check_value("dispatch_ready", 128'(1), 128'(dispatch_ready_o));

        // full buffer with the oldest entries done
        test_name = "flush";
        repeat (8) run_cycle(2, 2, NO_COMMIT, 1'b0);
        flush_cycle();
        run_cycle(0, 0, NO_COMMIT, 1'b0);
        check_value("commit_valid", 128'(0), 128'(commit_valid_o));
        check_value("dispatch_ready", 128'(1), 128'(dispatch_ready_o));

        // restarts at index 0 after the flush
        test_name = "random";
        repeat (RAND_CYCLES) begin
            run_cycle(int'(rand_bits(2)) % 3, int'(rand_bits(2)) % 3, RANDOM_COMMIT, 1'b0);
        end
        drain();
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * 100 + 2000);
        $display("watchdog: run did not finish within %0d cycles", TOTAL_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== rob/rob_top.sv ====
`default_nettype none

`include "rob_defines.svh"

module rob_top import rob_pkg::*; (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire                          flush_i,
    input  wire  rob_dispatch_t [1:0]    dispatch_i,
    input  wire  rob_cdb_t      [1:0]    cdb_i,
    input  wire  [1:0]                   commit_req_i,

    output logic                         dispatch_ready_o,
    output rob_src_reply_t [1:0]         src_reply_o,
    output logic [1:0]                   commit_valid_o,
    output rob_commit_t    [1:0]         commit_o
);

    logic [1:0][7:0][`ROB_WIDTH-1:0]   flag_raddr;
    logic [7:0]                        disp_flag;
    logic [7:0]                        cdb_flag;
    logic [1:0]                        disp_flag_wdata;
    logic [1:0]                        cdb_flag_wdata;
    logic [1:0][`ROB_WIDTH-1:0]        tail_id;
    logic [1:0][1:0]                   src_complete;
    logic [1:0][1:0][`ROB_DATA_W-1:0]  src_data;

    // write ports of the two flag tables
    logic [1:0]                        disp_we;
    logic [1:0][`ROB_WIDTH-1:0]        disp_waddr;
    logic [1:0]                        cdb_we;
    logic [1:0][`ROB_WIDTH-1:0]        cdb_waddr;

    assign disp_we    = {dispatch_i[1].valid, dispatch_i[0].valid};
    assign disp_waddr = {dispatch_i[1].rob_id, dispatch_i[0].rob_id};
    assign cdb_we     = {cdb_i[1].valid, cdb_i[0].valid};
    assign cdb_waddr  = {cdb_i[1].rob_id, cdb_i[0].rob_id};

    rob_status u_status (
        .clk,
        .reset_i,
        .flush_i,
        .dispatch_i,
        .cdb_i,
        .commit_req_i,
        .disp_flag_i       (disp_flag),
        .cdb_flag_i        (cdb_flag),
        .flag_raddr_o      (flag_raddr),
        .disp_flag_wdata_o (disp_flag_wdata),
        .cdb_flag_wdata_o  (cdb_flag_wdata),
        .tail_id_o         (tail_id),
        .commit_valid_o,
        .src_complete_o    (src_complete),
        .dispatch_ready_o
    );

    rob_entry_store u_store (
        .clk,
        .dispatch_i,
        .cdb_i,
        .tail_id_i  (tail_id),
        .commit_o,
        .src_data_o (src_data)
    );

    // dispatch side flags
    flag_table #(.R_PORTS(8)) u_disp_flags (
        .clk, .reset_i, .flush_i,
        .we_i (disp_we), .waddr_i (disp_waddr), .wdata_i (disp_flag_wdata),
        .raddr_i (flag_raddr[0]), .rdata_o (disp_flag)
    );

    // bus side flags
    flag_table #(.R_PORTS(8)) u_cdb_flags (
        .clk, .reset_i, .flush_i,
        .we_i (cdb_we), .waddr_i (cdb_waddr), .wdata_i (cdb_flag_wdata),
        .raddr_i (flag_raddr[1]), .rdata_o (cdb_flag)
    );

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_reply_o[s].data     = src_data[s];
            src_reply_o[s].complete = src_complete[s];
        end
    end

endmodule

`default_nettype wire

// ==== rob/rob_status.sv ====
`default_nettype none

`include "rob_defines.svh"

module rob_status import rob_pkg::*; (
    input  wire                                    clk,
    input  wire                                    reset_i,
    input  wire                                    flush_i,
    input  wire  rob_dispatch_t [1:0]              dispatch_i,
    input  wire  rob_cdb_t      [1:0]              cdb_i,
    input  wire  [1:0]                             commit_req_i,

    // reads of the dispatch and bus flag tables
    input  wire  [7:0]                             disp_flag_i,
    input  wire  [7:0]                             cdb_flag_i,

    // row 0 feeds the dispatch table, row 1 the bus table
    output logic [1:0][7:0][`ROB_WIDTH-1:0]        flag_raddr_o,
    output logic [1:0]                             disp_flag_wdata_o,
    output logic [1:0]                             cdb_flag_wdata_o,
    output logic [1:0][`ROB_WIDTH-1:0]             tail_id_o,

    output logic [1:0]                             commit_valid_o,
    output logic [1:0][1:0]                        src_complete_o,
    output logic                                   dispatch_ready_o
);

    ////////////////////////////////////////
    // pointer and count
    ////////////////////////////////////////

    logic [`ROB_WIDTH-1:0] tail_q;
    logic [`ROB_WIDTH:0]   count_q;
    logic [1:0]            n_disp;
    logic [1:0]            n_commit;

    assign n_disp   = 2'(dispatch_i[0].valid) + 2'(dispatch_i[1].valid);
    assign n_commit = 2'(commit_req_i[0]) + 2'(commit_req_i[1]);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            tail_q  <= tail_q + `ROB_WIDTH'(n_commit);
            count_q <= count_q + (`ROB_WIDTH+1)'(n_disp) - (`ROB_WIDTH+1)'(n_commit);
        end
    end

    assign tail_id_o[0] = tail_q;
    assign tail_id_o[1] = tail_q + `ROB_WIDTH'(1);

    // room for a full pair
    assign dispatch_ready_o = (count_q <= (`ROB_WIDTH+1)'(`ROB_DEPTH - 2));

    ////////////////////////////////////////
    // flag table addressing
    ////////////////////////////////////////

    // ports 0-1 tail, 2-5 sources, 6-7 the other table's write indices
    always_comb begin
        for (int t = 0; t < 2; t++) begin
            flag_raddr_o[t][0] = tail_id_o[0];
            flag_raddr_o[t][1] = tail_id_o[1];
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < 2; k++) begin
                    flag_raddr_o[t][2 + 2*s + k] = dispatch_i[s].src_id[k];
                end
            end
        end
        flag_raddr_o[0][6] = cdb_i[0].rob_id;
        flag_raddr_o[0][7] = cdb_i[1].rob_id;
        flag_raddr_o[1][6] = dispatch_i[0].rob_id;
        flag_raddr_o[1][7] = dispatch_i[1].rob_id;
    end

    ////////////////////////////////////////
    // completion
    ////////////////////////////////////////

    // complete when the two flags differ
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            commit_valid_o[i] = (count_q > (`ROB_WIDTH+1)'(i)) &&
                                (disp_flag_i[i] ^ cdb_flag_i[i]);
        end
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 2; k++) begin
                src_complete_o[s][k] = disp_flag_i[2 + 2*s + k] ^ cdb_flag_i[2 + 2*s + k];
            end
        end
    end

    // dispatch copies the bus flag, the bus inverts the dispatch flag
    assign disp_flag_wdata_o = cdb_flag_i[7:6];
    assign cdb_flag_wdata_o  = ~disp_flag_i[7:6];

    // commit stage must follow the offered valids, oldest first
    commit_req_a: assert property (
        @(posedge clk) disable iff (reset_i || flush_i)
        ((commit_req_i & ~commit_valid_o) == 2'b00) && !(commit_req_i[1] && !commit_req_i[0])
    ) else $error("rob_status: commit request %b with valid %b", commit_req_i, commit_valid_o);

    // dispatch respects back-pressure
    dispatch_ready_a: assert property (
        @(posedge clk) disable iff (reset_i || flush_i)
        (dispatch_i[0].valid || dispatch_i[1].valid) |-> dispatch_ready_o
    ) else $error("rob_status: dispatch while not ready, count %0d", count_q);

endmodule

`default_nettype wire

// ==== rob/rob_entry_store.sv ====
`default_nettype none

`include "rob_defines.svh"

module rob_entry_store import rob_pkg::*; (
    input  wire                                    clk,

    input  wire  rob_dispatch_t [1:0]              dispatch_i,
    input  wire  rob_cdb_t      [1:0]              cdb_i,
    input  wire  [1:0][`ROB_WIDTH-1:0]             tail_id_i,

    output rob_commit_t   [1:0]                    commit_o,
    // slot by source
    output logic [1:0][1:0][`ROB_DATA_W-1:0]       src_data_o
);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    // payload, written at dispatch
    logic [4:0]             areg_q   [`ROB_DEPTH];
    logic [31:0]            pc_q     [`ROB_DEPTH];
    inst_class_e            iclass_q [`ROB_DEPTH];

    // result, written from the bus
    logic [`ROB_DATA_W-1:0] data_q   [`ROB_DEPTH];

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            if (dispatch_i[s].valid) begin
                areg_q[dispatch_i[s].rob_id]   <= dispatch_i[s].areg;
                pc_q[dispatch_i[s].rob_id]     <= dispatch_i[s].pc;
                iclass_q[dispatch_i[s].rob_id] <= dispatch_i[s].iclass;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < 2; j++) begin
            if (cdb_i[j].valid) begin
                data_q[cdb_i[j].rob_id] <= cdb_i[j].data;
            end
        end
    end

    ////////////////////////////////////////
    // reads
    ////////////////////////////////////////

    // oldest two entries for commit
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            commit_o[i].areg   = areg_q[tail_id_i[i]];
            commit_o[i].pc     = pc_q[tail_id_i[i]];
            commit_o[i].iclass = iclass_q[tail_id_i[i]];
            commit_o[i].data   = data_q[tail_id_i[i]];
        end
    end

    // source operands, no bypass from the bus
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 2; k++) begin
                src_data_o[s][k] = data_q[dispatch_i[s].src_id[k]];
            end
        end
    end

    // a result for an entry being allocated right now would be lost
    for (genvar j = 0; j < 2; j++) begin : g_cdb_chk
        for (genvar s = 0; s < 2; s++) begin : g_disp_chk
            cdb_vs_dispatch_a: assert property (
                @(posedge clk)
                !(cdb_i[j].valid && dispatch_i[s].valid &&
                  (cdb_i[j].rob_id == dispatch_i[s].rob_id))
            ) else $error("rob_entry_store: bus writes entry %0d while it is dispatched",
                          cdb_i[j].rob_id);
        end
    end

endmodule

`default_nettype wire

// ==== logic/flag_table.sv ====
`default_nettype none

`include "rob_defines.svh"

module flag_table #(
    parameter int R_PORTS = 8
) (
    input  wire                               clk,
    input  wire                               reset_i,
    input  wire                               flush_i,

    // two write ports, port 1 has priority
    input  wire  [1:0]                        we_i,
    input  wire  [1:0][`ROB_WIDTH-1:0]        waddr_i,
    input  wire  [1:0]                        wdata_i,

    // asynchronous read ports
    input  wire  [R_PORTS-1:0][`ROB_WIDTH-1:0] raddr_i,
    output logic [R_PORTS-1:0]                rdata_o
);

    // one flag bit per entry
    logic [`ROB_DEPTH-1:0] flags_q;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            flags_q <= '0;
        end else begin
            if (we_i[0]) begin
                flags_q[waddr_i[0]] <= wdata_i[0];
            end
            // later assignment wins on equal addresses
            if (we_i[1]) begin
                flags_q[waddr_i[1]] <= wdata_i[1];
            end
        end
    end

    for (genvar r = 0; r < R_PORTS; r++) begin : g_read
        assign rdata_o[r] = flags_q[raddr_i[r]];
    end

    // both ports hitting one entry means the producer lost track of an index
    write_collision_a: assert property (
        @(posedge clk) disable iff (reset_i || flush_i)
        !(we_i[0] && we_i[1] && (waddr_i[0] == waddr_i[1]))
    ) else $error("flag_table: two writes to entry %0d", waddr_i[0]);

endmodule

`default_nettype wire

// ==== common/rob_pkg.sv ====
`default_nettype none

`include "rob_defines.svh"

package rob_pkg;

    // instruction class, carried through to commit
    typedef enum logic [1:0] {
        ALU    = 2'd0,
        MEM    = 2'd1,
        BRANCH = 2'd2,
        SYS    = 2'd3
    } inst_class_e;

    // one dispatch slot from rename
    typedef struct packed {
        logic                             valid;
        logic [`ROB_WIDTH-1:0]            rob_id;
        logic [4:0]                       areg;
        logic [31:0]                      pc;
        inst_class_e                      iclass;
        logic [1:0][`ROB_WIDTH-1:0]       src_id;
    } rob_dispatch_t;

    // one common data bus slot
    typedef struct packed {
        logic                             valid;
        logic [`ROB_WIDTH-1:0]            rob_id;
        logic [`ROB_DATA_W-1:0]           data;
    } rob_cdb_t;

    // answer to the two source lookups of one dispatch slot
    typedef struct packed {
        logic [1:0][`ROB_DATA_W-1:0]      data;
        logic [1:0]                       complete;
    } rob_src_reply_t;

    // one commit slot
    typedef struct packed {
        logic [4:0]                       areg;
        logic [31:0]                      pc;
        inst_class_e                      iclass;
        logic [`ROB_DATA_W-1:0]           data;
    } rob_commit_t;

endpackage

`default_nettype wire

// ==== common/rob_defines.svh ====
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// bits of a rob index
`define ROB_WIDTH 4

// number of entries
`define ROB_DEPTH 16

// result width on the bus
`define ROB_DATA_W 32

`endif
